// ==== design/decode_stage.sv ====
/*
 * Decode stage
 * Register file with write-through bypass, hazard comparators and the stall rule
 * Loads the ID/EX1 register and inserts a bubble while stalled
 */
`timescale 1ns/1ps

module decode_stage #(
	parameter int DATA_W = pipe_data_pkg::DATA_W
) (
	input  logic                             CLK,
	input  logic                             RSTB,
	input  logic [pipe_isa_pkg::INSTR_W-1:0] id_instr,
	input  logic                             wb_write,
	input  logic [pipe_data_pkg::REG_AW-1:0] wb_ra,
	input  logic [DATA_W-1:0]                wb_rd,
	output logic                             stall,
	output pipe_isa_pkg::op_t                ex1_op,
	output logic [pipe_data_pkg::REG_AW-1:0] ex1_ra,
	output logic [DATA_W-1:0]                ex1_xd,
	output logic                             ex1_xmex1,
	output logic                             ex1_xmex2
);

	pipe_isa_pkg::op_t                id_op;
	logic [pipe_data_pkg::REG_AW-1:0] id_ra;
	logic [pipe_data_pkg::REG_AW-1:0] id_xa;
	// Local copy of the destination index now sitting in EX2
	logic [pipe_data_pkg::REG_AW-1:0] ex2_ra_q;
	logic [DATA_W-1:0]                id_xd;
	logic [DATA_W-1:0]                regs [pipe_data_pkg::NUM_REGS];

	// ----------------------------------------------------------------------
	// Field split
	// ----------------------------------------------------------------------
	always_comb
	begin
		id_op.mov  = id_instr[pipe_isa_pkg::OP_MOV_BIT];
		id_op.sub3 = id_instr[pipe_isa_pkg::OP_SUB3_BIT];
		id_op.add4 = id_instr[pipe_isa_pkg::OP_ADD4_BIT];
		id_op.add1 = id_instr[pipe_isa_pkg::OP_ADD1_BIT];
	end

	assign id_ra = id_instr[pipe_isa_pkg::RA_LSB +: pipe_data_pkg::REG_AW];
	assign id_xa = id_instr[pipe_isa_pkg::XA_LSB +: pipe_data_pkg::REG_AW];

	// Register read with write-through
	// A write landing on XA this cycle is passed on before it reaches the array
	assign id_xd = (wb_write && (wb_ra == id_xa)) ? wb_rd : regs[id_xa];

	// SUB3 and ADD1 need their operand at the start of EX1, but an ADD4 or
	// ADD1 in EX1 only has its result at the end of EX2
	// That one case costs a single cycle of stall
	assign stall = (id_xa == ex1_ra) & (id_op.sub3 | id_op.add1) &
		(ex1_op.add4 | ex1_op.add1);

	// ----------------------------------------------------------------------
	// Register file
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			for (int i = 0; i < pipe_data_pkg::NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb_write)
		begin
			regs[wb_ra] <= wb_rd;
		end
	end

	// ----------------------------------------------------------------------
	// ID/EX1 register
	// ----------------------------------------------------------------------

	// Opcode flags are cleared under stall so a bubble enters EX1
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			ex1_op <= '0;
		else
			ex1_op <= stall ? '0 : id_op;
	end

	// Operand, index and match bits only matter alongside a live flag
	always_ff @(posedge CLK)
	begin
		ex1_ra <= id_ra;
		ex1_xd <= id_xd;
		// Match against EX1 now means a match against EX2 once we move up
		ex1_xmex1 <= (id_xa == ex1_ra);
		ex1_xmex2 <= (id_xa == ex2_ra_q);
		ex2_ra_q <= ex1_ra;
	end

endmodule

// ==== design/ex1_stage.sv ====
/*
 * EX1 stage
 * Operand forwarding from EX2 and write-back, the subtract-3 unit and the EX1/EX2 register
 */
`timescale 1ns/1ps

module ex1_stage #(
	parameter int DATA_W = pipe_data_pkg::DATA_W
) (
	input  logic                             CLK,
	input  logic                             RSTB,
	input  pipe_isa_pkg::op_t                ex1_op,
	input  logic [pipe_data_pkg::REG_AW-1:0] ex1_ra,
	input  logic [DATA_W-1:0]                ex1_xd,
	input  logic                             ex1_xmex1,
	input  logic                             ex1_xmex2,
	input  logic [DATA_W-1:0]                ex2_fwd,
	input  logic                             wb_write,
	input  logic [DATA_W-1:0]                wb_rd,
	output pipe_isa_pkg::op_t                ex2_op,
	output logic [pipe_data_pkg::REG_AW-1:0] ex2_ra,
	output logic [DATA_W-1:0]                ex2_xd,
	output logic                             ex2_xmex1
);

	logic              fwd_ex2;
	logic              fwd_wb;
	logic [DATA_W-1:0] operand;
	logic [DATA_W-1:0] diff;
	logic [DATA_W-1:0] result;

	// ----------------------------------------------------------------------
	// Priority and forwarding muxes
	// ----------------------------------------------------------------------

	// EX2 holds the younger value, so it wins over write-back
	// Only SUB3 and MOV have a final value while still in EX2
	assign fwd_ex2 = ex1_xmex1 & (ex2_op.sub3 | ex2_op.mov);
	assign fwd_wb  = ex1_xmex2 & wb_write;

	always_comb
	begin
		if (fwd_ex2)
			operand = ex2_fwd;
		else if (fwd_wb)
			operand = wb_rd;
		else
			operand = ex1_xd;
	end

	// Subtract-3 unit used by SUB3 and by the first half of ADD1
	assign diff = operand + DATA_W'(pipe_isa_pkg::EX1_DELTA);
	assign result = (ex1_op.sub3 | ex1_op.add1) ? diff : operand;

	// ----------------------------------------------------------------------
	// EX1/EX2 register
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			ex2_op <= '0;
		else
			ex2_op <= ex1_op;
	end

	always_ff @(posedge CLK)
	begin
		ex2_ra <= ex1_ra;
		ex2_xd <= result;
		ex2_xmex1 <= ex1_xmex1;
	end

endmodule

// ==== design/ex2_stage.sv ====
/*
 * EX2 stage
 * Write-back forwarding, the add-4 unit and the EX2/WB register that drives write-back
 */
`timescale 1ns/1ps

module ex2_stage #(
	parameter int DATA_W = pipe_data_pkg::DATA_W
) (
	input  logic                             CLK,
	input  logic                             RSTB,
	input  pipe_isa_pkg::op_t                ex2_op,
	input  logic [pipe_data_pkg::REG_AW-1:0] ex2_ra,
	input  logic [DATA_W-1:0]                ex2_xd,
	input  logic                             ex2_xmex1,
	output logic [DATA_W-1:0]                ex2_fwd,
	output logic                             wb_write,
	output logic [pipe_data_pkg::REG_AW-1:0] wb_ra,
	output logic [DATA_W-1:0]                wb_rd
);

	logic [DATA_W-1:0] sum;
	logic [DATA_W-1:0] result;

	// ----------------------------------------------------------------------
	// Write-back forwarding and add-4 unit
	// ----------------------------------------------------------------------

	// ADD4 and MOV skipped the EX1 unit, so they can still pick up a value
	// the instruction ahead of them is writing right now
	// The same corrected operand feeds the EX2-to-EX1 path
	assign ex2_fwd = (ex2_xmex1 & (ex2_op.add4 | ex2_op.mov) & wb_write) ?
		wb_rd : ex2_xd;

	// ADD1 finishes here after its subtract-3 in EX1
	assign sum = ex2_fwd + DATA_W'(pipe_isa_pkg::EX2_DELTA);
	assign result = (ex2_op.add4 | ex2_op.add1) ? sum : ex2_fwd;

	// ----------------------------------------------------------------------
	// EX2/WB register
	// ----------------------------------------------------------------------

	// Every real opcode writes its destination, bubbles and NOPs do not
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
			wb_write <= 1'b0;
		else
			wb_write <= |ex2_op;
	end

	always_ff @(posedge CLK)
	begin
		wb_ra <= ex2_ra;
		wb_rd <= result;
	end

endmodule

// ==== design/fetch_stage.sv ====
/*
 * Fetch stage
 * Program counter and the IF/ID register, both frozen while decode stalls
 */
`timescale 1ns/1ps

module fetch_stage #(
	parameter int PC_W = pipe_data_pkg::PC_W
) (
	input  logic                             CLK,
	input  logic                             RSTB,
	input  logic                             stall,
	input  logic [pipe_isa_pkg::INSTR_W-1:0] instr,
	output logic [PC_W-1:0]                  pc,
	output logic [pipe_isa_pkg::INSTR_W-1:0] id_instr
);

	// ----------------------------------------------------------------------
	// PC and IF/ID register
	// ----------------------------------------------------------------------

	// The instruction memory sits outside the core and answers pc in the
	// same cycle, so instr is captured straight into the IF/ID register
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			pc <= '0;
			// An all-zero word has no opcode bit and decodes as a NOP
			id_instr <= '0;
		end
		else if (!stall)
		begin
			pc <= pc + 1'b1;
			id_instr <= instr;
		end
		// On a stall both registers hold, so the dependent instruction
		// is decoded again next cycle and the word at pc is fetched again
	end

endmodule

// ==== design/pipe_core.sv ====
/*
 * Five-stage pipeline core
 * Fetch, decode, EX1, EX2 and write-back for MOV, SUB3, ADD4 and ADD1
 */
`timescale 1ns/1ps

module pipe_core #(
	parameter int DATA_W = pipe_data_pkg::DATA_W,
	parameter int PC_W   = pipe_data_pkg::PC_W
) (
	input  logic                             CLK,
	input  logic                             RSTB,
	input  logic [pipe_isa_pkg::INSTR_W-1:0] instr,
	output logic [PC_W-1:0]                  pc,
	output logic                             wb_write,
	output logic [pipe_data_pkg::REG_AW-1:0] wb_ra,
	output logic [DATA_W-1:0]                wb_rd
);

	// IF/ID and stall feedback
	logic                             stall;
	logic [pipe_isa_pkg::INSTR_W-1:0] id_instr;

	// ID/EX1
	pipe_isa_pkg::op_t                ex1_op;
	logic [pipe_data_pkg::REG_AW-1:0] ex1_ra;
	logic [DATA_W-1:0]                ex1_xd;
	logic                             ex1_xmex1;
	logic                             ex1_xmex2;

	// EX1/EX2 and the EX2-to-EX1 forwarding path
	pipe_isa_pkg::op_t                ex2_op;
	logic [pipe_data_pkg::REG_AW-1:0] ex2_ra;
	logic [DATA_W-1:0]                ex2_xd;
	logic                             ex2_xmex1;
	logic [DATA_W-1:0]                ex2_fwd;

	// ----------------------------------------------------------------------
	// Stages
	// ----------------------------------------------------------------------
	fetch_stage #(.PC_W(PC_W)) u_fetch (
		.CLK(CLK), .RSTB(RSTB), .stall(stall), .instr(instr),
		.pc(pc), .id_instr(id_instr)
	);

	// Decode also owns the register file, written from the write-back port
	decode_stage #(.DATA_W(DATA_W)) u_decode (
		.CLK(CLK), .RSTB(RSTB), .id_instr(id_instr),
		.wb_write(wb_write), .wb_ra(wb_ra), .wb_rd(wb_rd),
		.stall(stall), .ex1_op(ex1_op), .ex1_ra(ex1_ra), .ex1_xd(ex1_xd),
		.ex1_xmex1(ex1_xmex1), .ex1_xmex2(ex1_xmex2)
	);

	ex1_stage #(.DATA_W(DATA_W)) u_ex1 (
		.CLK(CLK), .RSTB(RSTB), .ex1_op(ex1_op), .ex1_ra(ex1_ra), .ex1_xd(ex1_xd),
		.ex1_xmex1(ex1_xmex1), .ex1_xmex2(ex1_xmex2), .ex2_fwd(ex2_fwd),
		.wb_write(wb_write), .wb_rd(wb_rd),
		.ex2_op(ex2_op), .ex2_ra(ex2_ra), .ex2_xd(ex2_xd), .ex2_xmex1(ex2_xmex1)
	);

	// The EX2/WB register inside this stage is the write-back port itself
	ex2_stage #(.DATA_W(DATA_W)) u_ex2 (
		.CLK(CLK), .RSTB(RSTB), .ex2_op(ex2_op), .ex2_ra(ex2_ra), .ex2_xd(ex2_xd),
		.ex2_xmex1(ex2_xmex1), .ex2_fwd(ex2_fwd),
		.wb_write(wb_write), .wb_ra(wb_ra), .wb_rd(wb_rd)
	);

endmodule

// ==== design/pipe_data_pkg.sv ====
/*
 * Datapath sizes of the five-stage pipeline
 * Data word, register index and program counter widths
 */
package pipe_data_pkg;

	// Default width of a register file entry
	localparam int DATA_W = 16;

	// Width of a register index in the instruction fields
	localparam int REG_AW = 4;

	// Default width of the fetch address
	localparam int PC_W = 8;

	// Number of entries in the register file
	// This matches the range of a REG_AW-bit index
	localparam int NUM_REGS = 16;

endpackage

// ==== design/pipe_isa_pkg.sv ====
/*
 * Instruction set of the five-stage pipeline
 * Opcode flag positions, operand fields and the fixed constants of the two adders
 */
package pipe_isa_pkg;

	// Width of one instruction word on the fetch port
	localparam int INSTR_W = 32;

	// Opcodes are one-hot in the top nibble
	// A word with no opcode bit set is treated as a NOP
	localparam int OP_MOV_BIT  = 31;
	localparam int OP_SUB3_BIT = 30;
	localparam int OP_ADD4_BIT = 29;
	localparam int OP_ADD1_BIT = 28;

	// Destination register index starts at bit 4, source index at bit 0
	localparam int RA_LSB = 4;
	localparam int XA_LSB = 0;

	// Constant applied by the subtract unit in EX1
	localparam int EX1_DELTA = -3;
	// Constant applied by the add unit in EX2
	localparam int EX2_DELTA = 4;

	// Decoded opcode flags that travel down the pipe with each instruction
	// All flags low marks a NOP or a bubble
	typedef struct packed {
		logic mov;
		logic sub3;
		logic add4;
		logic add1;
	} op_t;

endpackage

// ==== flist.f ====
design/pipe_isa_pkg.sv
design/pipe_data_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/ex1_stage.sv
design/ex2_stage.sv
design/pipe_core.sv
test/pipe_core_properties.sv
test/tb_pipe_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the pipeline testbench with Verilator, run it and scan the log for the fail message
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pipe_core -f flist.f \
	-o tb_pipe_core > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_pipe_core +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== test/pipe_core_properties.sv ====
/*
 * Concurrent checks on the pipeline core
 * Reset release, program counter progress and the one-cycle stall rule
 */
`timescale 1ns/1ps

module pipe_core_properties #(
	parameter int PC_W = pipe_data_pkg::PC_W
) (
	input logic            CLK,
	input logic            RSTB,
	input logic            stall,
	input logic [PC_W-1:0] pc,
	input logic            wb_write
);

	// Running count of assertion failures
	int fail_count = 0;

	// ----------------------------------------------------------------------
	// Reset release
	// ----------------------------------------------------------------------

	// Nothing can reach write-back in the first cycle out of reset
	wb_idle_after_reset: assert property (@(posedge CLK) $rose(RSTB) |=> !wb_write)
	else
	begin
		fail_count++;
		$error("wb_write high in the first cycle after reset");
	end

	// ----------------------------------------------------------------------
	// Fetch progress and stall
	// ----------------------------------------------------------------------

	// The fetch address only ever holds or steps by one
	pc_step: assert property (@(posedge CLK) disable iff (!RSTB)
		$past(RSTB) |-> ((pc == $past(pc)) || (pc == PC_W'($past(pc) + 1'b1))))
	else
	begin
		fail_count++;
		$error("pc neither held nor stepped by one");
	end

	// A stall inserts one bubble, so it cannot last a second cycle
	stall_single: assert property (@(posedge CLK) disable iff (!RSTB) stall |=> !stall)
	else
	begin
		fail_count++;
		$error("stall high for two cycles in a row");
	end

	// pc holds after a stall cycle and only then
	pc_hold_on_stall: assert property (@(posedge CLK) disable iff (!RSTB)
		$past(RSTB) |-> ((pc == $past(pc)) == $past(stall)))
	else
	begin
		fail_count++;
		$error("pc hold does not line up with stall");
	end

endmodule

bind pipe_core pipe_core_properties #(.PC_W(PC_W)) props (
	.CLK(CLK), .RSTB(RSTB), .stall(stall), .pc(pc), .wb_write(wb_write)
);

// ==== test/tb_pipe_core.sv ====
/*
 * Testbench for the five-stage pipeline core
 * Program memory model, shadow register file, write-back checks and watchdog
 */
`timescale 1ns/1ps

module tb_pipe_core;

	localparam int DATA_W = 16;
	localparam int PC_W = 8;
	localparam int CLK_PERIOD = 20;
	localparam int K_NOP = 0;
	localparam int K_MOV = 1;
	localparam int K_SUB3 = 2;
	localparam int K_ADD4 = 3;
	localparam int K_ADD1 = 4;

	logic                             CLK;
	logic                             RSTB;
	logic [pipe_isa_pkg::INSTR_W-1:0] instr;
	logic [PC_W-1:0]                  pc;
	logic                             wb_write;
	logic [pipe_data_pkg::REG_AW-1:0] wb_ra;
	logic [DATA_W-1:0]                wb_rd;

	// Program memory, every word past the program stays a NOP
	logic [pipe_isa_pkg::INSTR_W-1:0] prog [2**PC_W];
	int prog_len = 0;
	logic prog_ready = 1'b0;

	// Shadow register file and the writes expected on the write-back port, oldest first
	logic [DATA_W-1:0] shadow [pipe_data_pkg::NUM_REGS];
	int exp_ra [$];
	logic [DATA_W-1:0] exp_val [$];
	string exp_name [$];
	int pending = 0;

	// The word before the current one, for the stall rule
	int prev_kind = K_NOP;
	int prev_ra = 0;
	int exp_stalls = 0;
	int held_cycles = 0;
	int errors = 0;
	logic [PC_W-1:0] last_pc = '0;
	logic last_rstb = 1'b0;

	pipe_core #(.DATA_W(DATA_W), .PC_W(PC_W)) uut (
		.CLK(CLK), .RSTB(RSTB), .instr(instr), .pc(pc),
		.wb_write(wb_write), .wb_ra(wb_ra), .wb_rd(wb_rd)
	);

	initial
	begin
		CLK = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) CLK = ~CLK;
		end
	end

	// ----------------------------------------------------------------------
	// Program building and shadow model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] encode(input int kind, input int ra, input int xa);
		logic [31:0] w;
		w = '0;
		case (kind)
			K_MOV: w[pipe_isa_pkg::OP_MOV_BIT] = 1'b1;
			K_SUB3: w[pipe_isa_pkg::OP_SUB3_BIT] = 1'b1;
			K_ADD4: w[pipe_isa_pkg::OP_ADD4_BIT] = 1'b1;
			K_ADD1: w[pipe_isa_pkg::OP_ADD1_BIT] = 1'b1;
			default: w = '0;
		endcase
		w[pipe_isa_pkg::RA_LSB +: 4] = ra[3:0];
		w[pipe_isa_pkg::XA_LSB +: 4] = xa[3:0];
		return w;
	endfunction

	// Appends one word and runs it on the shadow file in program order
	task automatic add_instr(input int kind, input int ra, input int xa, input string name);
		logic [DATA_W-1:0] src;
		logic [DATA_W-1:0] val;
		src = shadow[xa];
		case (kind)
			K_SUB3: val = src - 16'd3;
			K_ADD4: val = src + 16'd4;
			K_ADD1: val = src + 16'd1;
			default: val = src;
		endcase
		// SUB3 or ADD1 right behind a dependent ADD4 or ADD1 holds fetch for one cycle
		if ((kind == K_SUB3 || kind == K_ADD1) && (prev_kind == K_ADD4 || prev_kind == K_ADD1)
			&& xa == prev_ra)
			exp_stalls++;
		prog[prog_len] = encode(kind, ra, xa);
		prog_len++;
		if (kind != K_NOP)
		begin
			shadow[ra] = val;
			exp_ra.push_back(ra);
			exp_val.push_back(val);
			exp_name.push_back(name);
			pending++;
		end
		prev_kind = kind;
		prev_ra = ra;
	endtask

	task automatic add_nops(input int count, input string name);
		for (int i = 0; i < count; i++)
			add_instr(K_NOP, 0, 0, name);
	endtask

	task automatic build_programs();
		int kind;
		int ra;
		int xa;
		// Fresh registers must read back as zero
		add_nops(2, "reset_zero");
		add_instr(K_MOV, 1, 0, "reset_zero");
		add_instr(K_MOV, 2, 5, "reset_zero");
		add_instr(K_MOV, 3, 15, "reset_zero");
		add_nops(3, "reset_zero");
		// Each opcode alone, far enough apart that no forwarding is needed
		add_instr(K_ADD4, 4, 4, "independent");
		add_nops(3, "independent");
		add_instr(K_SUB3, 5, 6, "independent");
		add_nops(3, "independent");
		add_instr(K_ADD1, 6, 7, "independent");
		add_nops(3, "independent");
		add_instr(K_MOV, 7, 4, "independent");
		add_nops(4, "independent");
		// MOV after ADD4 takes WB into EX2, SUB3 and ADD4 after MOV or SUB3 take EX2 into EX1
		add_instr(K_ADD4, 1, 1, "forward_chain");
		add_instr(K_MOV, 2, 1, "forward_chain");
		add_instr(K_SUB3, 3, 2, "forward_chain");
		add_instr(K_ADD4, 4, 3, "forward_chain");
		// Two slots behind its producer, so this one takes WB into EX1
		add_instr(K_SUB3, 5, 3, "forward_chain");
		add_instr(K_MOV, 6, 5, "forward_chain");
		add_instr(K_ADD4, 7, 6, "forward_chain");
		add_nops(4, "forward_chain");
		add_instr(K_ADD4, 8, 8, "stall_hazard");
		add_instr(K_SUB3, 9, 8, "stall_hazard");
		add_nops(1, "stall_hazard");
		add_instr(K_ADD4, 10, 9, "stall_hazard");
		add_instr(K_ADD1, 10, 10, "stall_hazard");
		add_instr(K_ADD1, 11, 10, "stall_hazard");
		add_nops(4, "stall_hazard");
		// Readers three slots behind the writer meet it at the register file
		add_instr(K_ADD4, 12, 12, "rf_bypass");
		add_nops(2, "rf_bypass");
		add_instr(K_MOV, 13, 12, "rf_bypass");
		add_nops(2, "rf_bypass");
		add_instr(K_SUB3, 14, 13, "rf_bypass");
		add_nops(4, "rf_bypass");
		for (int i = 0; i < 40; i++)
		begin
			kind = $urandom_range(4, 0);
			ra = $urandom_range(15, 0);
			xa = $urandom_range(15, 0);
			add_instr(kind, ra, xa, "random");
		end
	endtask

	// ----------------------------------------------------------------------
	// Stimulus and checks
	// ----------------------------------------------------------------------

	// The program memory answers pc a short time after each edge
	initial
	begin
		instr = '0;
		forever
		begin
			@(posedge CLK);
			#2;
			instr = prog[pc];
		end
	end

	task automatic check_write();
		assert (pending > 0)
		else
		begin
			errors++;
			$display("Write to r%0d arrived after every expected write was seen", wb_ra);
		end
		if (pending > 0)
		begin
			assert (wb_ra == exp_ra[0] && wb_rd == exp_val[0])
			else
			begin
				errors++;
				$display("MISMATCH %s: expected r%0d = %h, actual r%0d = %h",
					exp_name[0], exp_ra[0], exp_val[0], wb_ra, wb_rd);
			end
			void'(exp_ra.pop_front());
			void'(exp_val.pop_front());
			void'(exp_name.pop_front());
			pending--;
		end
	endtask

	// Outputs are sampled mid-cycle, well away from the edge that updates them
	always @(negedge CLK)
	begin
		if (RSTB && wb_write)
			check_write();
		if (RSTB && last_rstb && pc == last_pc)
			held_cycles++;
		last_pc = pc;
		last_rstb = RSTB;
	end

	initial
	begin
		RSTB = 1'b0;
		for (int r = 0; r < pipe_data_pkg::NUM_REGS; r++)
			shadow[r] = '0;
		for (int a = 0; a < 2**PC_W; a++)
			prog[a] = '0;
		void'($urandom(32'h640a));
		build_programs();
		prog_ready = 1'b1;
		repeat (3) @(posedge CLK);
		#2;
		RSTB = 1'b1;
		wait (pending == 0);
		// Let the pipe drain so that a stray extra write is still caught
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		assert (held_cycles == exp_stalls)
		else
		begin
			errors++;
			$display("MISMATCH stall_count: expected %0d held pc cycles, actual %0d",
				exp_stalls, held_cycles);
		end
		$display("Errors: %0d testbench checks, %0d property failures",
			errors, uut.props.fail_count);
		if (errors == 0 && uut.props.fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog sized from the program length, with room for every possible stall
	initial
	begin
		wait (prog_ready);
		#((2 * prog_len + 20) * CLK_PERIOD);
		$display("Timeout: %0d expected writes never reached the write-back port", pending);
		$display("Simulation failed");
		$finish;
	end

endmodule
